// File: hdl/pool_pkg.sv
package pool_pkg;

  localparam int DWIDTH    = 16;
  localparam int AWIDTH    = 8;
  localparam int MEM_DEPTH = 256;
  localparam int LWIDTH    = 4;
  localparam int PAWIDTH   = 12;  // APB byte address

  // Input map from word 0, results from OUT_BASE
  localparam logic [AWIDTH-1:0] OUT_BASE = 8'd128;

  localparam logic [LWIDTH-1:0] MAX_FEA  = 4'd11;
  localparam logic [LWIDTH-1:0] MAX_POOL = 4'd4;

  localparam logic [PAWIDTH-1:0] REG_CTRL      = 12'h000;
  localparam logic [PAWIDTH-1:0] REG_FEA_SIZE  = 12'h004;
  localparam logic [PAWIDTH-1:0] REG_POOL_SIZE = 12'h008;
  localparam logic [PAWIDTH-1:0] REG_STATUS    = 12'h00C;
  localparam logic [PAWIDTH-1:0] MEM_WIN       = 12'h400;  // word n at MEM_WIN + 4n

  typedef struct packed {
    logic start;
    logic valid;
    logic last;   // last pixel of a window
    logic stop;   // last pixel of the frame
  } ctrl_t;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [AWIDTH-1:0] addr;
    logic [DWIDTH-1:0] wdata;
  } mem_req_t;

  typedef enum logic {
    S_WAIT,
    S_ACTIVE
  } pool_state_e;

  typedef enum logic [1:0] {
    SRC_WB,
    SRC_RD,
    SRC_APB
  } arb_src_e;

endpackage

// File: hdl/pool_apb_regs.sv
`timescale 1ns/1ps

module pool_apb_regs
  ( input  logic                         clk
  , input  logic                         xrst
  , input  logic                         psel
  , input  logic                         penable
  , input  logic                         pwrite
  , input  logic [pool_pkg::PAWIDTH-1:0] paddr
  , input  logic [pool_pkg::DWIDTH-1:0]  pwdata
  , input  logic                         busy
  , input  logic                         frame_done
  , input  logic                         apb_gnt
  , input  logic [pool_pkg::DWIDTH-1:0]  rdata
  , output logic [pool_pkg::DWIDTH-1:0]  prdata
  , output logic                         pready
  , output logic                         pslverr
  , output logic                         start_frame
  , output logic [pool_pkg::LWIDTH-1:0]  fea_size
  , output logic [pool_pkg::LWIDTH-1:0]  pool_size
  , output pool_pkg::mem_req_t           apb_req
  );

  logic access;
  logic mem_sel;
  logic reg_wr;
  logic ctrl_wr;
  logic cfg_ok;
  logic rd_wait;   // RAM data arrives this cycle
  logic done_q;

  assign access = psel && penable;

  // Window spans 4 * MEM_DEPTH bytes above MEM_WIN
  assign mem_sel = paddr[pool_pkg::PAWIDTH-1:10] == pool_pkg::MEM_WIN[pool_pkg::PAWIDTH-1:10];

  assign reg_wr  = access && pwrite && !mem_sel;
  assign ctrl_wr = reg_wr && paddr == pool_pkg::REG_CTRL && pwdata[0];

  assign cfg_ok = !busy
               && pool_size != '0
               && pool_size <= fea_size
               && pool_size <= pool_pkg::MAX_POOL
               && fea_size <= pool_pkg::MAX_FEA;

  assign start_frame = ctrl_wr && cfg_ok;
  assign pslverr     = ctrl_wr && !cfg_ok;

  // Registers finish at once, memory waits on the arbiter
  assign pready = access && (!mem_sel || (pwrite ? apb_gnt : rd_wait));

  always_comb begin
    apb_req.req   = access && mem_sel && !rd_wait;
    apb_req.we    = pwrite;
    apb_req.addr  = paddr[pool_pkg::AWIDTH+1:2];
    apb_req.wdata = pwdata;
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      rd_wait <= 1'b0;
    else
      rd_wait <= apb_req.req && apb_gnt && !pwrite;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      fea_size  <= '0;
      pool_size <= '0;
      done_q    <= 1'b0;
    end
    else begin
      if (reg_wr && paddr == pool_pkg::REG_FEA_SIZE)
        fea_size <= pwdata[pool_pkg::LWIDTH-1:0];
      if (reg_wr && paddr == pool_pkg::REG_POOL_SIZE)
        pool_size <= pwdata[pool_pkg::LWIDTH-1:0];
      if (start_frame)
        done_q <= 1'b0;
      else if (frame_done)
        done_q <= 1'b1;   // Sticky until next start
    end
  end

  always_comb begin
    prdata = '0;
    if (mem_sel)
      prdata = rdata;
    else
      case (paddr)
        pool_pkg::REG_FEA_SIZE:  prdata[pool_pkg::LWIDTH-1:0] = fea_size;
        pool_pkg::REG_POOL_SIZE: prdata[pool_pkg::LWIDTH-1:0] = pool_size;
        pool_pkg::REG_STATUS:    prdata[1:0] = {done_q, busy};
        default:                 prdata = '0;
      endcase
  end

  a_penable_psel: assert property (@(posedge clk) disable iff (!xrst) penable |-> psel);

endmodule

// File: hdl/pool_mem_arb.sv
`timescale 1ns/1ps

module pool_mem_arb
  ( input  logic               clk
  , input  logic               xrst
  , input  pool_pkg::mem_req_t wb_req
  , input  pool_pkg::mem_req_t rd_req
  , input  pool_pkg::mem_req_t apb_req
  , output logic               wb_gnt
  , output logic               rd_gnt
  , output logic               apb_gnt
  , output pool_pkg::mem_req_t mem_bus
  );

  pool_pkg::arb_src_e src;
  logic               any_req;

  // Write-back first, then engine reads, APB last
  always_comb begin
    any_req = wb_req.req || rd_req.req || apb_req.req;
    if (wb_req.req)
      src = pool_pkg::SRC_WB;
    else if (rd_req.req)
      src = pool_pkg::SRC_RD;
    else
      src = pool_pkg::SRC_APB;
  end

  assign wb_gnt  = any_req && src == pool_pkg::SRC_WB;
  assign rd_gnt  = any_req && src == pool_pkg::SRC_RD;
  assign apb_gnt = any_req && src == pool_pkg::SRC_APB;

  always_comb begin
    case (src)
      pool_pkg::SRC_WB:  mem_bus = wb_req;
      pool_pkg::SRC_RD:  mem_bus = rd_req;
      default:           mem_bus = apb_req;
    endcase
    if (!any_req)
      mem_bus = '0;
  end

  a_gnt_onehot: assert property (@(posedge clk) disable iff (!xrst)
    $onehot0({wb_gnt, rd_gnt, apb_gnt}));

  a_gnt_has_req: assert property (@(posedge clk) disable iff (!xrst)
    (wb_gnt |-> wb_req.req) and (rd_gnt |-> rd_req.req) and (apb_gnt |-> apb_req.req));

  // A stalled engine read must not move
  a_rd_hold: assert property (@(posedge clk) disable iff (!xrst)
    rd_req.req && !rd_gnt |=> rd_req == $past(rd_req));

endmodule

// File: hdl/pool_feat_mem.sv
`timescale 1ns/1ps

module pool_feat_mem
  ( input  logic                        clk
  , input  pool_pkg::mem_req_t          mem_bus
  , output logic [pool_pkg::DWIDTH-1:0] rdata
  );

  logic [pool_pkg::DWIDTH-1:0] mem [pool_pkg::MEM_DEPTH];

  // Read returns the old word on a write cycle
  always_ff @(posedge clk) begin
    if (mem_bus.req) begin
      if (mem_bus.we)
        mem[mem_bus.addr] <= mem_bus.wdata;
      rdata <= mem[mem_bus.addr];
    end
  end

endmodule

// File: hdl/pool_ctrl.sv
`timescale 1ns/1ps

module pool_ctrl
  ( input  logic                        clk
  , input  logic                        xrst
  , input  logic                        start_frame
  , input  logic [pool_pkg::LWIDTH-1:0] fea_size
  , input  logic [pool_pkg::LWIDTH-1:0] pool_size
  , input  logic                        rd_gnt
  , input  logic                        frame_done
  , output pool_pkg::mem_req_t          rd_req
  , output pool_pkg::ctrl_t             ctrl_out
  , output logic                        busy
  );

  pool_pkg::pool_state_e state;

  logic [pool_pkg::LWIDTH-1:0] fea_q;
  logic [pool_pkg::LWIDTH-1:0] pool_q;
  logic [pool_pkg::LWIDTH-1:0] ox;   // output column
  logic [pool_pkg::LWIDTH-1:0] oy;   // output row
  logic [pool_pkg::LWIDTH-1:0] wx;
  logic [pool_pkg::LWIDTH-1:0] wy;
  logic [pool_pkg::AWIDTH-1:0] fea_w;
  logic [pool_pkg::AWIDTH-1:0] pool_w;
  logic [pool_pkg::AWIDTH-1:0] ox_w;
  logic [pool_pkg::AWIDTH-1:0] oy_w;
  logic [pool_pkg::AWIDTH-1:0] row_pos;
  logic [pool_pkg::AWIDTH-1:0] col_pos;
  logic wx_last;
  logic wy_last;
  logic ox_last;
  logic oy_last;
  logic win_last;
  logic frame_last;
  logic first_pix;
  logic reads_done;

  assign fea_w  = pool_pkg::AWIDTH'(fea_q);
  assign pool_w = pool_pkg::AWIDTH'(pool_q);
  assign ox_w   = pool_pkg::AWIDTH'(ox);
  assign oy_w   = pool_pkg::AWIDTH'(oy);

  assign wx_last = wx == pool_q - 1'b1;
  assign wy_last = wy == pool_q - 1'b1;
  assign ox_last = (ox_w + pool_pkg::AWIDTH'(2)) * pool_w > fea_w;  // next window won't fit
  assign oy_last = (oy_w + pool_pkg::AWIDTH'(2)) * pool_w > fea_w;

  assign win_last   = wx_last && wy_last;
  assign frame_last = win_last && ox_last && oy_last;
  assign first_pix  = ox == '0 && oy == '0 && wx == '0 && wy == '0;

  assign row_pos = oy_w * pool_w + pool_pkg::AWIDTH'(wy);
  assign col_pos = ox_w * pool_w + pool_pkg::AWIDTH'(wx);

  always_comb begin
    rd_req.req   = state == pool_pkg::S_ACTIVE && !reads_done;
    rd_req.we    = 1'b0;
    rd_req.addr  = row_pos * fea_w + col_pos;
    rd_req.wdata = '0;
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      state <= pool_pkg::S_WAIT;
    else
      case (state)
        pool_pkg::S_WAIT:
          if (start_frame)
            state <= pool_pkg::S_ACTIVE;
        pool_pkg::S_ACTIVE:
          if (ctrl_out.stop)
            state <= pool_pkg::S_WAIT;
        default:
          state <= pool_pkg::S_WAIT;
      endcase
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      fea_q  <= '0;
      pool_q <= '0;
      busy   <= 1'b0;
    end
    else begin
      if (state == pool_pkg::S_WAIT && start_frame) begin
        fea_q  <= fea_size;
        pool_q <= pool_size;
      end
      if (start_frame)
        busy <= 1'b1;
      else if (frame_done)
        busy <= 1'b0;   // Held until the last result is written
    end
  end

  // Window pixels row by row, then windows left to right, top to bottom
  always_ff @(posedge clk) begin
    if (!xrst) begin
      ox         <= '0;
      oy         <= '0;
      wx         <= '0;
      wy         <= '0;
      reads_done <= 1'b0;
    end
    else if (start_frame) begin
      ox         <= '0;
      oy         <= '0;
      wx         <= '0;
      wy         <= '0;
      reads_done <= 1'b0;
    end
    else if (rd_gnt) begin
      if (frame_last)
        reads_done <= 1'b1;
      if (!wx_last)
        wx <= wx + 1'b1;
      else begin
        wx <= '0;
        if (!wy_last)
          wy <= wy + 1'b1;
        else begin
          wy <= '0;
          if (!ox_last)
            ox <= ox + 1'b1;
          else begin
            ox <= '0;
            oy <= oy_last ? '0 : oy + 1'b1;
          end
        end
      end
    end
  end

  // One stage, lines up with the RAM read latency
  always_ff @(posedge clk) begin
    if (!xrst)
      ctrl_out <= '0;
    else
      ctrl_out <= '{start: rd_gnt && first_pix,
                    valid: rd_gnt,
                    last:  rd_gnt && win_last,
                    stop:  rd_gnt && frame_last};
  end

  a_wait_quiet: assert property (@(posedge clk) disable iff (!xrst)
    state == pool_pkg::S_WAIT |-> !rd_req.req && !ctrl_out.valid);

endmodule

// File: hdl/pool_max.sv
`timescale 1ns/1ps

module pool_max
  ( input  logic                        clk
  , input  logic                        xrst
  , input  pool_pkg::ctrl_t             ctrl_out
  , input  logic [pool_pkg::DWIDTH-1:0] rdata
  , input  logic                        wb_gnt
  , output pool_pkg::mem_req_t          wb_req
  , output logic                        frame_done
  );

  logic [pool_pkg::DWIDTH-1:0] acc;
  logic [pool_pkg::DWIDTH-1:0] cur_max;
  logic [pool_pkg::AWIDTH-1:0] cnt;
  logic [pool_pkg::AWIDTH-1:0] res_idx;
  logic                        fresh;      // next pixel opens a window
  logic                        stop_pend;
  logic                        take_new;

  assign take_new = ctrl_out.start || fresh;
  assign cur_max  = (take_new || rdata > acc) ? rdata : acc;
  assign res_idx  = ctrl_out.start ? '0 : cnt;

  always_ff @(posedge clk) begin
    if (ctrl_out.valid)
      acc <= cur_max;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      fresh     <= 1'b1;
      cnt       <= '0;
      stop_pend <= 1'b0;
    end
    else if (ctrl_out.valid) begin
      fresh <= ctrl_out.last;
      if (ctrl_out.last) begin
        cnt       <= res_idx + 1'b1;
        stop_pend <= ctrl_out.stop;
      end
      else if (ctrl_out.start)
        cnt <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      wb_req <= '0;
    else begin
      if (wb_req.req && wb_gnt)
        wb_req.req <= 1'b0;
      if (ctrl_out.valid && ctrl_out.last)
        wb_req <= '{req:   1'b1,
                    we:    1'b1,
                    addr:  pool_pkg::OUT_BASE + res_idx,
                    wdata: cur_max};
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      frame_done <= 1'b0;
    else
      frame_done <= wb_req.req && wb_gnt && stop_pend;
  end

  // Pending write must clear before the next window closes
  a_one_pending: assert property (@(posedge clk) disable iff (!xrst)
    ctrl_out.valid && ctrl_out.last |-> !wb_req.req || wb_gnt);

endmodule

// File: hdl/pool_top.sv
`timescale 1ns/1ps

module pool_top
  ( input  logic                         clk
  , input  logic                         xrst
  , input  logic                         psel
  , input  logic                         penable
  , input  logic                         pwrite
  , input  logic [pool_pkg::PAWIDTH-1:0] paddr
  , input  logic [pool_pkg::DWIDTH-1:0]  pwdata
  , output logic [pool_pkg::DWIDTH-1:0]  prdata
  , output logic                         pready
  , output logic                         pslverr
  , output logic                         done
  );

  logic                        start_frame;
  logic [pool_pkg::LWIDTH-1:0] fea_size;
  logic [pool_pkg::LWIDTH-1:0] pool_size;
  logic                        busy;
  logic                        frame_done;
  logic                        wb_gnt;
  logic                        rd_gnt;
  logic                        apb_gnt;
  logic [pool_pkg::DWIDTH-1:0] rdata;
  pool_pkg::mem_req_t          wb_req;
  pool_pkg::mem_req_t          rd_req;
  pool_pkg::mem_req_t          apb_req;
  pool_pkg::mem_req_t          mem_bus;
  pool_pkg::ctrl_t             ctrl_out;

  assign done = frame_done;

  pool_apb_regs pool_apb_regs_i
    ( .clk, .xrst, .psel, .penable, .pwrite, .paddr, .pwdata
    , .busy, .frame_done, .apb_gnt, .rdata
    , .prdata, .pready, .pslverr, .start_frame, .fea_size, .pool_size, .apb_req
    );

  pool_ctrl pool_ctrl_i
    ( .clk, .xrst, .start_frame, .fea_size, .pool_size, .rd_gnt, .frame_done
    , .rd_req, .ctrl_out, .busy
    );

  pool_max pool_max_i
    ( .clk, .xrst, .ctrl_out, .rdata, .wb_gnt, .wb_req, .frame_done );

  pool_mem_arb pool_mem_arb_i
    ( .clk, .xrst, .wb_req, .rd_req, .apb_req
    , .wb_gnt, .rd_gnt, .apb_gnt, .mem_bus
    );

  pool_feat_mem pool_feat_mem_i
    ( .clk, .mem_bus, .rdata );

endmodule

// File: dv/pool_tb.sv
`timescale 1ns/1ps

module pool_tb;

  localparam int CLK_HALF   = 4;
  // ~400 APB transfers of 3 to 4 cycles each, four frames under 150 cycles, wide margin
  localparam int MAX_CYCLES = 20000;

  logic                         clk;
  logic                         xrst;
  logic                         psel;
  logic                         penable;
  logic                         pwrite;
  logic [pool_pkg::PAWIDTH-1:0] paddr;
  logic [pool_pkg::DWIDTH-1:0]  pwdata;
  logic [pool_pkg::DWIDTH-1:0]  prdata;
  logic                         pready;
  logic                         pslverr;
  logic                         done;

  logic [pool_pkg::DWIDTH-1:0] fmap [pool_pkg::MEM_DEPTH];  // map last loaded
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  pool_top pool_top_i
    ( .clk, .xrst, .psel, .penable, .pwrite, .paddr, .pwdata
    , .prdata, .pready, .pslverr, .done
    );

  always #CLK_HALF clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, a transfer or a frame never finished", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // Max of window (r, c), stride equals pool size
  function automatic logic [pool_pkg::DWIDTH-1:0] pool_ref(input int fea, input int pool,
                                                          input int r, input int c);
    logic [pool_pkg::DWIDTH-1:0] m;
    int idx;
    m = '0;
    for (int y = 0; y < pool; y++)
      for (int x = 0; x < pool; x++) begin
        idx = (r * pool + y) * fea + c * pool + x;
        if (fmap[idx] > m)
          m = fmap[idx];
      end
    return m;
  endfunction

  function automatic logic [pool_pkg::PAWIDTH-1:0] word_addr(input int n);
    return pool_pkg::MEM_WIN + pool_pkg::PAWIDTH'(4 * n);
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic apb_xfer(input logic wr, input logic [pool_pkg::PAWIDTH-1:0] addr,
                          input logic [pool_pkg::DWIDTH-1:0] wdata,
                          output logic [pool_pkg::DWIDTH-1:0] rdata, output logic err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    while (!pready)
      @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [pool_pkg::PAWIDTH-1:0] addr,
                           input logic [pool_pkg::DWIDTH-1:0] wdata, output logic err);
    logic [pool_pkg::DWIDTH-1:0] unused;
    apb_xfer(1'b1, addr, wdata, unused, err);
  endtask

  task automatic apb_read(input logic [pool_pkg::PAWIDTH-1:0] addr,
                          output logic [pool_pkg::DWIDTH-1:0] rdata);
    logic err;
    apb_xfer(1'b0, addr, '0, rdata, err);
    check("read_no_slverr", 0, err);
  endtask

  task automatic load_map(input int fea);
    logic err;
    for (int i = 0; i < fea * fea; i++) begin
      fmap[i] = 16'($urandom);
      apb_write(word_addr(i), fmap[i], err);
    end
  endtask

  task automatic launch_frame(input int fea, input int pool);
    logic err;
    apb_write(pool_pkg::REG_FEA_SIZE, 16'(fea), err);
    apb_write(pool_pkg::REG_POOL_SIZE, 16'(pool), err);
    apb_write(pool_pkg::REG_CTRL, 16'h1, err);
    check("start_accepted", 0, err);
  endtask

  task automatic wait_done;
    do
      @(negedge clk);
    while (!done);
    @(negedge clk);
    check("done_pulse", 0, done);  // one cycle wide
  endtask

  task automatic check_results(input string name, input int fea, input int pool);
    logic [pool_pkg::DWIDTH-1:0] data;
    int n;
    n = fea / pool;
    for (int r = 0; r < n; r++)
      for (int c = 0; c < n; c++) begin
        apb_read(word_addr(int'(pool_pkg::OUT_BASE) + r * n + c), data);
        check(name, pool_ref(fea, pool, r, c), data);
      end
  endtask

  initial begin
    logic [pool_pkg::DWIDTH-1:0] data;
    logic [pool_pkg::DWIDTH-1:0] words [16];
    logic err;
    clk     = 1'b0;
    xrst    = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    void'($urandom(32'hcfe8));
    repeat (4) @(posedge clk);
    #1;
    xrst = 1'b1;

    apb_read(pool_pkg::REG_STATUS, data);
    check("status_after_reset", 0, data);
    apb_write(pool_pkg::REG_FEA_SIZE, 16'h1b, err);  // upper bits dropped
    apb_read(pool_pkg::REG_FEA_SIZE, data);
    check("fea_size_readback", 16'hb, data);
    apb_write(pool_pkg::REG_POOL_SIZE, 16'h3, err);
    apb_read(pool_pkg::REG_POOL_SIZE, data);
    check("pool_size_readback", 16'h3, data);

    for (int i = 0; i < 16; i++) begin
      words[i] = 16'($urandom);
      apb_write(word_addr(200 + i), words[i], err);
    end
    for (int i = 0; i < 16; i++) begin
      apb_read(word_addr(200 + i), data);
      check("mem_window", words[i], data);
    end

    load_map(8);
    launch_frame(8, 2);
    wait_done();
    apb_read(pool_pkg::REG_STATUS, data);
    check("status_done", 16'h2, data);
    check_results("pool2_fea8", 8, 2);

    // Leftover row and column ignored
    load_map(7);
    launch_frame(7, 3);
    wait_done();
    check_results("pool3_fea7", 7, 3);

    load_map(5);
    launch_frame(5, 1);
    wait_done();
    for (int i = 0; i < 25; i++) begin
      apb_read(word_addr(int'(pool_pkg::OUT_BASE) + i), data);
      check("copy_fea5", fmap[i], data);
    end

    apb_write(pool_pkg::REG_FEA_SIZE, 16'd5, err);
    apb_write(pool_pkg::REG_POOL_SIZE, 16'd0, err);
    apb_write(pool_pkg::REG_CTRL, 16'h1, err);
    check("slverr_pool0", 1, err);
    apb_read(pool_pkg::REG_STATUS, data);
    check("idle_pool0", 0, data[0]);
    apb_write(pool_pkg::REG_POOL_SIZE, 16'd6, err);
    apb_write(pool_pkg::REG_CTRL, 16'h1, err);
    check("slverr_pool_gt_fea", 1, err);
    apb_read(pool_pkg::REG_STATUS, data);
    check("idle_pool_gt_fea", 0, data[0]);

    load_map(8);
    launch_frame(8, 2);
    apb_read(pool_pkg::REG_STATUS, data);
    check("status_busy", 1, data[0]);
    for (int i = 0; i < 8; i++) begin
      apb_read(word_addr(i * 9), data);  // stalls behind engine reads
      check("input_while_busy", fmap[i * 9], data);
    end
    do
      apb_read(pool_pkg::REG_STATUS, data);
    while (!data[1]);
    check_results("pool2_after_busy", 8, 2);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: compile.f
hdl/pool_pkg.sv
hdl/pool_apb_regs.sv
hdl/pool_mem_arb.sv
hdl/pool_feat_mem.sv
hdl/pool_ctrl.sv
hdl/pool_max.sv
hdl/pool_top.sv
dv/pool_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= pool_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
